//--- include/dds_macros.svh
`ifndef DDS_MACROS_SVH
`define DDS_MACROS_SVH

// frame and record lengths in bits, all shifted out MSB first
`define DDS_RECORD_BITS 184
`define DDS_INIT_BITS 232
`define DDS_UNCLEAR_BITS 40

// number of sweep records the store can hold
`define DDS_SWEEP_SLOTS 4

// phase lengths in SCLK_PE_3 cycles
`define DDS_IO_RESET_CYCLES 5 // io_reset pulse that frames the serial port
`define DDS_UPDATE_CYCLES 5 // io_update pulse after each init frame
`define DDS_GAP_CYCLES 8 // idle time between two phases
`define DDS_DR_SETTLE_CYCLES 8 // delay from the first to the second dr_ctl level

// register image sent once at init
// limits at 0x0b are zeroed and CFR1 at 0x00 sets the ramp accumulator clear bit
// CFR2 at 0x01 turns the digital ramp on with the parallel data clock off
// CFR3 at 0x02 selects VCO5 with the PLL on and N of 100
// the aux DAC at 0x03 is set to the lowest full scale current
`define DDS_INIT_IMAGE { \
	8'h0b, 32'h0000_0000, 32'h0000_0000, \
	8'h00, 32'h0000_1000, \
	8'h01, 32'h0048_0020, \
	8'h02, 32'h353f_c1c8, \
	8'h03, 32'h0000_0000 \
}

// CFR1 written back with the accumulator clear bit low so the ramp can run
`define DDS_UNCLEAR_IMAGE {8'h00, 32'h0000_0000}

`endif

//--- source/dds_regs_pkg.sv
`default_nettype none

`include "dds_macros.svh"

package dds_regs_pkg;

	// one sweep record as the chip sees it on sdio, step_addr goes out first
	typedef struct packed {
		logic [7:0] step_addr; // digital ramp step size register address
		logic [31:0] fall_step; // decrement step, the first word after the address
		logic [31:0] rise_step; // increment step
		logic [`DDS_RECORD_BITS-73:0] ramp_rest; // limits and rate words that follow
	} sweep_record_t;

	// init frame, four 40-bit register writes behind the 72-bit limit write
	typedef struct packed {
		logic [7:0] limit_addr;
		logic [31:0] upper_limit;
		logic [31:0] lower_limit;
		logic [7:0] cfr1_addr;
		logic [31:0] cfr1_data; // accumulator clear set here
		logic [7:0] cfr2_addr;
		logic [31:0] cfr2_data;
		logic [7:0] cfr3_addr;
		logic [31:0] cfr3_data;
		logic [7:0] aux_dac_addr;
		logic [31:0] aux_dac_data;
	} init_frame_t;

	// single register write that drops the accumulator clear again
	typedef struct packed {
		logic [7:0] cfr1_addr;
		logic [31:0] cfr1_data;
	} unclear_frame_t;

	// sweep direction taken from the two step sizes of a record
	typedef enum logic [1:0] {
		ramp_rise, // low to high, fall_step is the larger one
		ramp_fall, // high to low
		ramp_hold // equal steps, dr_ctl keeps its level
	} ramp_dir_t;

	typedef logic [$clog2(`DDS_SWEEP_SLOTS)-1:0] slot_idx_t;
	typedef logic [$clog2(`DDS_SWEEP_SLOTS+1)-1:0] slot_count_t; // 0 up to a full store

endpackage

`default_nettype wire

//--- source/dds_ctrl_pkg.sv
`default_nettype none

package dds_ctrl_pkg;

	// everything that goes to the DDS chip pins
	typedef struct packed {
		logic sdio; // serial data, valid while sclk is low
		logic sclk; // serial clock, the chip samples on its rising edge
		logic io_update; // moves the written registers into the active set
		logic io_reset; // resets the chip serial port
		logic dr_ctl; // digital ramp direction
	} dds_pins_t;

	// one bit of a host record
	typedef struct packed {
		logic valid; // single cycle
		logic data;
	} load_bit_t;

	// host requests, each a one cycle strobe
	typedef struct packed {
		logic init_start; // send the register image
		logic sweep_start; // play the next stored record
		logic clear_store; // forget all stored records
	} ctrl_req_t;

endpackage

`default_nettype wire

//--- source/serial_frame_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module serial_frame_shifter #(
	parameter type payload_t = logic [7:0]
) (
	input logic SCLK_PE_3,
	input logic reset_flag,
	input logic start,
	input payload_t frame,
	output logic sdio,
	output logic sclk,
	output logic busy,
	output logic done
);

	localparam int W = $bits(payload_t);
	localparam int CNT_W = $clog2(W);

	logic [W-1:0] shift_reg; // frame copy, the top bit is on sdio
	logic [CNT_W-1:0] bit_cnt; // bits already sent
	logic phase; // low half of the bit when 0, high half when 1

	assign sdio = busy & shift_reg[W-1]; // held through both halves of a bit
	assign sclk = busy & phase;

	// frame register, loaded on start and moved up one bit after every high half
	always_ff @(posedge SCLK_PE_3)
	begin
		if (start && !busy)
			shift_reg <= frame;
		else if (busy && phase)
			shift_reg <= {shift_reg[W-2:0], 1'b0}; // next bit moves up after the high half
	end

	always_ff @(posedge SCLK_PE_3)
	begin
		if (reset_flag)
		begin
			busy <= 1'b0;
			phase <= 1'b0;
			bit_cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start && !busy)
			begin
				busy <= 1'b1; // first low half starts next cycle
				phase <= 1'b0;
				bit_cnt <= '0;
			end
			else if (busy)
			begin
				phase <= ~phase;
				if (phase)
				begin
					if (bit_cnt == CNT_W'(W - 1))
					begin
						busy <= 1'b0; // last high half is over
						done <= 1'b1;
					end
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// the sequencers wait for done before they start another frame
	a_no_start_while_busy: assert property (@(posedge SCLK_PE_3) disable iff (reset_flag)
		start |-> !busy);

endmodule

`default_nettype wire

//--- source/sweep_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_macros.svh"

module sweep_store (
	input logic SCLK_PE_3,
	input logic reset_flag,
	input dds_ctrl_pkg::load_bit_t load_bit,
	input logic clear_store,
	input dds_regs_pkg::slot_idx_t rd_slot,
	output dds_regs_pkg::sweep_record_t rd_record,
	output dds_regs_pkg::slot_count_t stored_count
);

	localparam int BIT_CNT_W = $clog2(`DDS_RECORD_BITS);

	logic [`DDS_RECORD_BITS-2:0] asm_reg; // all bits of a record but the last one
	logic [BIT_CNT_W-1:0] bit_cnt; // bits of the current record received so far
	dds_regs_pkg::sweep_record_t slots [`DDS_SWEEP_SLOTS];
	logic store_full;
	logic last_bit; // this valid bit completes a record

	assign store_full = (stored_count == dds_regs_pkg::slot_count_t'(`DDS_SWEEP_SLOTS));
	assign last_bit = load_bit.valid && !store_full
		&& (bit_cnt == BIT_CNT_W'(`DDS_RECORD_BITS - 1));

	// the player reads the slot at its sweep index directly
	assign rd_record = slots[rd_slot];

	// assembly register and record slots
	always_ff @(posedge SCLK_PE_3)
	begin
		if (load_bit.valid && !store_full)
			asm_reg <= {asm_reg[`DDS_RECORD_BITS-3:0], load_bit.data}; // first bit ends up on top
		if (last_bit)
		begin
			slots[stored_count[$bits(dds_regs_pkg::slot_idx_t)-1:0]] <=
				dds_regs_pkg::sweep_record_t'({asm_reg, load_bit.data});
		end
	end

	always_ff @(posedge SCLK_PE_3)
	begin
		if (reset_flag)
		begin
			bit_cnt <= '0;
			stored_count <= '0;
		end
		else if (clear_store)
		begin
			bit_cnt <= '0; // a partly received record is thrown away too
			stored_count <= '0;
		end
		else if (last_bit)
		begin
			bit_cnt <= '0;
			stored_count <= stored_count + 1'b1; // count shows the new record from the next cycle
		end
		else if (load_bit.valid && !store_full)
			bit_cnt <= bit_cnt + 1'b1;
	end

	a_count_in_range: assert property (@(posedge SCLK_PE_3) disable iff (reset_flag)
		stored_count <= dds_regs_pkg::slot_count_t'(`DDS_SWEEP_SLOTS));

endmodule

`default_nettype wire

//--- source/init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_macros.svh"

module init_sequencer (
	input logic SCLK_PE_3,
	input logic reset_flag,
	input logic init_start,
	input logic player_busy,
	output dds_ctrl_pkg::dds_pins_t pins,
	output logic dds_ready,
	output logic init_done
);

	localparam int CNT_W = 8;

	typedef enum logic [3:0] {
		st_idle,
		st_io_reset,
		st_gap_a, // before the init frame
		st_init_frame,
		st_gap_b,
		st_update_a, // accumulator gets cleared here
		st_gap_c,
		st_unclear_frame,
		st_gap_d,
		st_update_b
	} phase_t;

	phase_t phase;
	phase_t timed_next; // where a timed phase goes once it runs out
	logic [CNT_W-1:0] cnt; // cycles spent in the current timed phase
	logic [CNT_W-1:0] phase_last;
	logic init_go; // start strobes for the two shifters
	logic unclear_go;
	logic init_sdio, init_sclk, init_shift_done;
	logic unclear_sdio, unclear_sclk, unclear_shift_done;

	always_comb
	begin
		phase_last = CNT_W'(`DDS_GAP_CYCLES - 1); // gaps are the usual case
		timed_next = st_idle;
		case (phase)
			st_io_reset:
			begin
				phase_last = CNT_W'(`DDS_IO_RESET_CYCLES - 1);
				timed_next = st_gap_a;
			end
			st_gap_a: timed_next = st_init_frame;
			st_gap_b: timed_next = st_update_a;
			st_update_a:
			begin
				phase_last = CNT_W'(`DDS_UPDATE_CYCLES - 1);
				timed_next = st_gap_c;
			end
			st_gap_c: timed_next = st_unclear_frame;
			st_gap_d: timed_next = st_update_b;
			st_update_b: phase_last = CNT_W'(`DDS_UPDATE_CYCLES - 1); // back to idle
			default: timed_next = st_idle;
		endcase
	end

	always_ff @(posedge SCLK_PE_3)
	begin
		if (reset_flag)
		begin
			phase <= st_idle;
			cnt <= '0;
			init_go <= 1'b0;
			unclear_go <= 1'b0;
			dds_ready <= 1'b0;
			init_done <= 1'b0;
		end
		else
		begin
			init_go <= 1'b0;
			unclear_go <= 1'b0;
			init_done <= 1'b0;
			case (phase)
				st_idle:
				begin
					cnt <= '0;
					if (init_start && !player_busy) // a running sweep blocks a new init
					begin
						phase <= st_io_reset;
						dds_ready <= 1'b0; // chip is being rewritten
					end
				end
				st_init_frame:
					if (init_shift_done)
						phase <= st_gap_b;
				st_unclear_frame:
					if (unclear_shift_done)
						phase <= st_gap_d;
				default:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == phase_last)
					begin
						cnt <= '0;
						phase <= timed_next;
						init_go <= (phase == st_gap_a); // frames start as their phase begins
						unclear_go <= (phase == st_gap_c);
						if (phase == st_update_b)
						begin
							init_done <= 1'b1;
							dds_ready <= 1'b1;
						end
					end
				end
			endcase
		end
	end

	serial_frame_shifter #(.payload_t(dds_regs_pkg::init_frame_t)) init_shifter_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.start(init_go),
		.frame(dds_regs_pkg::init_frame_t'(`DDS_INIT_IMAGE)),
		.sdio(init_sdio),
		.sclk(init_sclk),
		.busy(),
		.done(init_shift_done)
	);

	serial_frame_shifter #(.payload_t(dds_regs_pkg::unclear_frame_t)) unclear_shifter_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.start(unclear_go),
		.frame(dds_regs_pkg::unclear_frame_t'(`DDS_UNCLEAR_IMAGE)),
		.sdio(unclear_sdio),
		.sclk(unclear_sclk),
		.busy(),
		.done(unclear_shift_done)
	);

	// idle shifters drive 0 so the two can simply be ORed
	assign pins = '{
		sdio: init_sdio | unclear_sdio,
		sclk: init_sclk | unclear_sclk,
		io_update: (phase == st_update_a) || (phase == st_update_b),
		io_reset: (phase == st_io_reset),
		dr_ctl: 1'b0
	};

endmodule

`default_nettype wire

//--- source/ramp_direction_ctl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_macros.svh"

module ramp_direction_ctl (
	input logic SCLK_PE_3,
	input logic reset_flag,
	input dds_regs_pkg::sweep_record_t record,
	input logic update_fire,
	output logic dr_ctl,
	output logic settled
);

	localparam int CNT_W = 8;

	dds_regs_pkg::ramp_dir_t dir_now; // direction of the record being played
	dds_regs_pkg::ramp_dir_t dir_q; // kept for the second level
	logic settling;
	logic [CNT_W-1:0] settle_cnt;

	// the unused direction carries the larger step, usually all ones
	always_comb
	begin
		if (record.fall_step > record.rise_step)
			dir_now = dds_regs_pkg::ramp_rise;
		else if (record.fall_step < record.rise_step)
			dir_now = dds_regs_pkg::ramp_fall;
		else
			dir_now = dds_regs_pkg::ramp_hold;
	end

	always_ff @(posedge SCLK_PE_3)
	begin
		if (reset_flag)
		begin
			dr_ctl <= 1'b0;
			dir_q <= dds_regs_pkg::ramp_hold;
			settling <= 1'b0;
			settle_cnt <= '0;
			settled <= 1'b0;
		end
		else
		begin
			settled <= 1'b0;
			if (update_fire)
			begin
				dir_q <= dir_now;
				settling <= 1'b1;
				settle_cnt <= '0;
				// first level shows up together with io_update
				// a rising sweep starts at the lower limit so dr_ctl goes low first
				case (dir_now)
					dds_regs_pkg::ramp_rise: dr_ctl <= 1'b0;
					dds_regs_pkg::ramp_fall: dr_ctl <= 1'b1;
					default: dr_ctl <= dr_ctl;
				endcase
			end
			else if (settling)
			begin
				if (settle_cnt == CNT_W'(`DDS_DR_SETTLE_CYCLES - 1))
				begin
					settling <= 1'b0;
					settled <= 1'b1; // player may go idle now
					case (dir_q)
						dds_regs_pkg::ramp_rise: dr_ctl <= 1'b1; // ramp now runs upward
						dds_regs_pkg::ramp_fall: dr_ctl <= 1'b0;
						default: dr_ctl <= dr_ctl;
					endcase
				end
				else
					settle_cnt <= settle_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/sweep_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_macros.svh"

module sweep_player (
	input logic SCLK_PE_3,
	input logic reset_flag,
	input logic sweep_start,
	input logic dds_ready,
	input dds_regs_pkg::slot_count_t stored_count,
	input dds_regs_pkg::sweep_record_t record,
	output dds_ctrl_pkg::dds_pins_t pins,
	output logic busy,
	output dds_regs_pkg::slot_idx_t sweep_index,
	output logic sequence_done
);

	localparam int CNT_W = 8;

	typedef enum logic [1:0] {
		st_idle,
		st_shift, // record goes out on sdio
		st_gap,
		st_settle // io_update sent, waiting for the second dr_ctl level
	} play_state_t;

	play_state_t state;
	logic [CNT_W-1:0] gap_cnt;
	logic go; // accepted sweep_start
	logic update_fire; // last gap cycle, io_update and dr_ctl follow at the next edge
	logic io_update_q;
	logic shift_sdio, shift_sclk, shift_done;
	logic dr_ctl, settled;
	dds_regs_pkg::slot_count_t next_count; // index plus one, compared against the count

	assign go = sweep_start && dds_ready && (stored_count != '0) && (state == st_idle);
	assign update_fire = (state == st_gap) && (gap_cnt == CNT_W'(`DDS_GAP_CYCLES - 1));
	assign next_count = dds_regs_pkg::slot_count_t'(sweep_index) + 1'b1;
	assign busy = (state != st_idle);

	always_ff @(posedge SCLK_PE_3)
	begin
		if (reset_flag)
		begin
			state <= st_idle;
			gap_cnt <= '0;
			io_update_q <= 1'b0;
			sweep_index <= '0;
			sequence_done <= 1'b0;
		end
		else
		begin
			io_update_q <= update_fire; // single cycle pulse
			sequence_done <= 1'b0;
			case (state)
				st_idle:
					if (go)
						state <= st_shift;
				st_shift:
					if (shift_done)
					begin
						state <= st_gap;
						gap_cnt <= '0;
					end
				st_gap:
				begin
					gap_cnt <= gap_cnt + 1'b1;
					if (update_fire)
						state <= st_settle;
				end
				default:
					if (settled)
					begin
						state <= st_idle;
						if (next_count >= stored_count) // last record played, start over
						begin
							sweep_index <= '0;
							sequence_done <= 1'b1;
						end
						else
							sweep_index <= dds_regs_pkg::slot_idx_t'(next_count);
					end
			endcase
		end
	end

	serial_frame_shifter #(.payload_t(dds_regs_pkg::sweep_record_t)) record_shifter_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.start(go),
		.frame(record),
		.sdio(shift_sdio),
		.sclk(shift_sclk),
		.busy(),
		.done(shift_done)
	);

	ramp_direction_ctl ramp_direction_ctl_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.record(record),
		.update_fire(update_fire),
		.dr_ctl(dr_ctl),
		.settled(settled)
	);

	assign pins = '{
		sdio: shift_sdio,
		sclk: shift_sclk,
		io_update: io_update_q,
		io_reset: 1'b0,
		dr_ctl: dr_ctl // holds its level between sweeps
	};

	// the init sequencer leaves dds_ready alone while a sweep is running
	a_ready_while_busy: assert property (@(posedge SCLK_PE_3) disable iff (reset_flag)
		busy |-> dds_ready);

endmodule

`default_nettype wire

//--- source/dds_sweep_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dds_sweep_ctrl (
	input logic SCLK_PE_3,
	input logic reset_flag,
	input dds_ctrl_pkg::ctrl_req_t ctrl_req,
	input dds_ctrl_pkg::load_bit_t load_bit,
	output dds_ctrl_pkg::dds_pins_t dds_pins,
	output logic dds_ready,
	output logic init_done,
	output logic sequence_done,
	output dds_regs_pkg::slot_count_t stored_count,
	output dds_regs_pkg::slot_idx_t sweep_index
);

	dds_ctrl_pkg::dds_pins_t init_pins; // zero unless the init sequence runs
	dds_ctrl_pkg::dds_pins_t play_pins;
	dds_regs_pkg::sweep_record_t play_record; // record at the current sweep index
	logic player_busy;

	sweep_store sweep_store_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.load_bit(load_bit),
		.clear_store(ctrl_req.clear_store),
		.rd_slot(sweep_index),
		.rd_record(play_record),
		.stored_count(stored_count)
	);

	init_sequencer init_sequencer_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.init_start(ctrl_req.init_start),
		.player_busy(player_busy),
		.pins(init_pins),
		.dds_ready(dds_ready),
		.init_done(init_done)
	);

	sweep_player sweep_player_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.sweep_start(ctrl_req.sweep_start),
		.dds_ready(dds_ready),
		.stored_count(stored_count),
		.record(play_record),
		.pins(play_pins),
		.busy(player_busy),
		.sweep_index(sweep_index),
		.sequence_done(sequence_done)
	);

	// only one side is active at a time, dr_ctl from the init side is always 0
	assign dds_pins = init_pins | play_pins;

endmodule

`default_nettype wire

//--- verif/tb_dds_sweep_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dds_macros.svh"

module tb_dds_sweep_ctrl;

	// rough phase lengths in clock cycles, used to size the timeout
	localparam int INIT_LEN = `DDS_IO_RESET_CYCLES + 4 * `DDS_GAP_CYCLES
		+ 2 * `DDS_UPDATE_CYCLES + 2 * (`DDS_INIT_BITS + `DDS_UNCLEAR_BITS) + 8;
	localparam int SWEEP_LEN = 2 * `DDS_RECORD_BITS + `DDS_GAP_CYCLES + `DDS_DR_SETTLE_CYCLES + 8;
	localparam int LOAD_LEN = 3 * 4 * `DDS_RECORD_BITS; // a host bit takes at most four cycles
	localparam int TIMEOUT_CYCLES = 3 * (INIT_LEN + 4 * SWEEP_LEN) + LOAD_LEN + 200;
	localparam int QUIET_CYCLES = 40; // an ignored request must stay silent this long

	// what one record should do to dr_ctl
	typedef struct packed {
		dds_regs_pkg::ramp_dir_t dir;
		logic first; // level at io_update
		logic second; // level after the settle delay
	} ramp_exp_t;

	logic SCLK_PE_3;
	logic reset_flag;
	dds_ctrl_pkg::ctrl_req_t ctrl_req;
	dds_ctrl_pkg::load_bit_t load_bit;
	dds_ctrl_pkg::dds_pins_t dds_pins;
	logic dds_ready;
	logic init_done;
	logic sequence_done;
	dds_regs_pkg::slot_count_t stored_count;
	dds_regs_pkg::slot_idx_t sweep_index;

	int mismatch_count = 0;
	int fail_count = 0;
	int cycle_count = 0;

	logic [255:0] cap_data; // bits of the frame being captured, last bit at the bottom
	int cap_bits;
	int sclk_edges;
	int update_pulses;
	int reset_pulses;
	logic prev_sclk;
	logic prev_update;
	logic prev_reset;
	logic [255:0] frame_q[$]; // one entry per io_update, the frame that came before it
	int frame_len_q[$];
	logic dr_at_update_q[$]; // dr_ctl seen in the first io_update cycle

	dds_regs_pkg::sweep_record_t records[3];

	dds_sweep_ctrl dds_sweep_ctrl_i (
		.SCLK_PE_3(SCLK_PE_3),
		.reset_flag(reset_flag),
		.ctrl_req(ctrl_req),
		.load_bit(load_bit),
		.dds_pins(dds_pins),
		.dds_ready(dds_ready),
		.init_done(init_done),
		.sequence_done(sequence_done),
		.stored_count(stored_count),
		.sweep_index(sweep_index)
	);

	always #5 SCLK_PE_3 = ~SCLK_PE_3;

	// pin monitor, outputs only change after a rising edge so the falling edge sees them settled
	always @(negedge SCLK_PE_3)
	begin
		if (reset_flag)
		begin
			cap_data = '0;
			cap_bits = 0;
			sclk_edges = 0;
			update_pulses = 0;
			reset_pulses = 0;
		end
		else
		begin
			if (dds_pins.sclk && !prev_sclk) // sclk is high for exactly one clock per bit
			begin
				cap_data = {cap_data[254:0], dds_pins.sdio};
				cap_bits++;
				sclk_edges++;
			end
			if (dds_pins.io_reset && !prev_reset)
			begin
				reset_pulses++;
				if (cap_bits != 0)
				begin
					$display("error at %0t: io_reset arrived in the middle of a frame", $time);
					fail_count++;
				end
			end
			if (dds_pins.io_update && !prev_update)
			begin
				update_pulses++;
				frame_q.push_back(cap_data); // io_update closes the frame before it
				frame_len_q.push_back(cap_bits);
				dr_at_update_q.push_back(dds_pins.dr_ctl);
				cap_data = '0;
				cap_bits = 0;
			end
		end
		prev_sclk = reset_flag ? 1'b0 : dds_pins.sclk;
		prev_update = reset_flag ? 1'b0 : dds_pins.io_update;
		prev_reset = reset_flag ? 1'b0 : dds_pins.io_reset;
	end

	always @(posedge SCLK_PE_3)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ramp rule: the larger falling step marks a rising sweep, equal steps keep the level
	function automatic ramp_exp_t expected_ramp(input dds_regs_pkg::sweep_record_t rec,
		input logic level_before);
		ramp_exp_t r;
		if (rec.fall_step > rec.rise_step)
			r = '{dds_regs_pkg::ramp_rise, 1'b0, 1'b1};
		else if (rec.fall_step < rec.rise_step)
			r = '{dds_regs_pkg::ramp_fall, 1'b1, 1'b0};
		else
			r = '{dds_regs_pkg::ramp_hold, level_before, level_before};
		return r;
	endfunction

	// direction as it shows on the pin
	function automatic dds_regs_pkg::ramp_dir_t observed_dir(input logic first, input logic second);
		if (!first && second)
			return dds_regs_pkg::ramp_rise;
		else if (first && !second)
			return dds_regs_pkg::ramp_fall;
		return dds_regs_pkg::ramp_hold;
	endfunction

	function automatic dds_regs_pkg::sweep_record_t random_record(
		input dds_regs_pkg::ramp_dir_t dir);
		dds_regs_pkg::sweep_record_t rec;
		logic [127:0] rest;
		logic [31:0] a;
		logic [31:0] b;
		a = $urandom();
		b = $urandom();
		if (a == b)
			b = ~a; // the two steps must differ unless a hold is wanted
		rest = {$urandom(), $urandom(), $urandom(), $urandom()};
		rec.step_addr = 8'($urandom());
		rec.ramp_rest = rest[`DDS_RECORD_BITS-73:0];
		case (dir)
			dds_regs_pkg::ramp_rise:
			begin
				rec.fall_step = (a > b) ? a : b;
				rec.rise_step = (a > b) ? b : a;
			end
			dds_regs_pkg::ramp_fall:
			begin
				rec.fall_step = (a > b) ? b : a;
				rec.rise_step = (a > b) ? a : b;
			end
			default:
			begin
				rec.fall_step = a;
				rec.rise_step = a;
			end
		endcase
		return rec;
	endfunction

	task automatic compare_init(input dds_regs_pkg::init_frame_t got,
		input dds_regs_pkg::init_frame_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: init frame got %h expected %h", $time, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_unclear(input dds_regs_pkg::unclear_frame_t got,
		input dds_regs_pkg::unclear_frame_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: unclear frame got %h expected %h", $time, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_record(input dds_regs_pkg::sweep_record_t got,
		input dds_regs_pkg::sweep_record_t exp, input int slot);
		if (got !== exp)
		begin
			$display("mismatch at %0t: record %0d got %h expected %h", $time, slot, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_dir(input dds_regs_pkg::ramp_dir_t got,
		input dds_regs_pkg::ramp_dir_t exp, input int slot);
		if (got !== exp)
		begin
			$display("mismatch at %0t: record %0d direction got %s expected %s", $time, slot,
				got.name(), exp.name());
			mismatch_count++;
		end
	endtask

	task automatic compare_count(input dds_regs_pkg::slot_count_t got,
		input dds_regs_pkg::slot_count_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: stored_count got %0d expected %0d", $time, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_pins(input dds_ctrl_pkg::dds_pins_t got,
		input dds_ctrl_pkg::dds_pins_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: dds_pins got %b expected %b", $time, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic compare_int(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			mismatch_count++;
		end
	endtask

	// one cycle request strobe, returns on the falling edge after it
	task automatic pulse_request(input dds_ctrl_pkg::ctrl_req_t req);
		ctrl_req = req;
		@(negedge SCLK_PE_3);
		ctrl_req = '0;
		@(negedge SCLK_PE_3);
	endtask

	// host bits go out first field first with random idle gaps
	task automatic send_record(input dds_regs_pkg::sweep_record_t rec);
		logic [`DDS_RECORD_BITS-1:0] bits;
		int idle;
		bits = rec;
		for (int i = `DDS_RECORD_BITS - 1; i >= 0; i--)
		begin
			load_bit = '{1'b1, bits[i]};
			@(negedge SCLK_PE_3);
			load_bit = '0;
			idle = $urandom_range(2, 0);
			repeat (idle) @(negedge SCLK_PE_3);
		end
	endtask

	task automatic take_frame(output logic [255:0] data, output int len, output logic dr_first,
		output logic ok);
		ok = (frame_q.size() != 0);
		data = '0;
		len = 0;
		dr_first = 1'b0;
		if (ok)
		begin
			data = frame_q.pop_front();
			len = frame_len_q.pop_front();
			dr_first = dr_at_update_q.pop_front();
		end
		else
		begin
			$display("error at %0t: no captured frame where one was expected", $time);
			fail_count++;
		end
	endtask

	initial
	begin
		logic [255:0] frame;
		int len;
		logic dr_first;
		logic ok;
		logic level_before;
		logic ready_before;
		ramp_exp_t exp_ramp;
		int updates_before;
		int edges_before;
		dds_regs_pkg::slot_idx_t next_index;

		void'($urandom(32'h1f55e5d9));
		SCLK_PE_3 = 1'b0;
		reset_flag = 1'b1;
		ctrl_req = '0;
		load_bit = '0;
		repeat (4) @(negedge SCLK_PE_3);
		reset_flag = 1'b0;
		@(negedge SCLK_PE_3);

		// everything quiet after reset
		compare_pins(dds_pins, '0);
		compare_bit(dds_ready, 1'b0, "dds_ready after reset");
		compare_count(stored_count, '0);

		// the hold record sits after the rising one so it has to keep a high level
		records[0] = random_record(dds_regs_pkg::ramp_rise);
		records[1] = random_record(dds_regs_pkg::ramp_hold);
		records[2] = random_record(dds_regs_pkg::ramp_fall);
		for (int i = 0; i < 3; i++)
			send_record(records[i]);
		compare_count(stored_count, 3);

		// records are there but the chip is not set up yet, so a sweep does nothing
		pulse_request('{1'b0, 1'b1, 1'b0});
		repeat (QUIET_CYCLES) @(negedge SCLK_PE_3);
		compare_int(sclk_edges, 0, "sclk edges before init");

		pulse_request('{1'b1, 1'b0, 1'b0});
		while (!init_done)
		begin
			ready_before = dds_ready;
			@(negedge SCLK_PE_3);
		end
		compare_bit(ready_before, 1'b0, "dds_ready before init_done");
		compare_bit(dds_ready, 1'b1, "dds_ready with init_done"); // both rise on the same edge
		compare_int(reset_pulses, 1, "io_reset pulses");
		compare_int(update_pulses, 2, "io_update pulses during init");
		take_frame(frame, len, dr_first, ok);
		compare_int(len, `DDS_INIT_BITS, "init frame length");
		compare_init(frame[`DDS_INIT_BITS-1:0], `DDS_INIT_IMAGE);
		take_frame(frame, len, dr_first, ok);
		compare_int(len, `DDS_UNCLEAR_BITS, "unclear frame length");
		compare_unclear(frame[`DDS_UNCLEAR_BITS-1:0], `DDS_UNCLEAR_IMAGE);

		level_before = dds_pins.dr_ctl;
		for (int i = 0; i < 3; i++)
		begin
			updates_before = update_pulses;
			exp_ramp = expected_ramp(records[i], level_before);
			next_index = dds_regs_pkg::slot_idx_t'((i + 1) % 3);
			pulse_request('{1'b0, 1'b1, 1'b0});
			while (sweep_index != next_index) @(negedge SCLK_PE_3); // index moves once dr_ctl settled
			compare_bit(sequence_done, (i == 2), "sequence_done");
			compare_int(update_pulses - updates_before, 1, "io_update pulses per sweep");
			take_frame(frame, len, dr_first, ok);
			if (ok)
			begin
				compare_int(len, `DDS_RECORD_BITS, "record frame length");
				compare_record(frame[`DDS_RECORD_BITS-1:0], records[i], i);
				compare_bit(dr_first, exp_ramp.first, "dr_ctl at io_update");
				compare_bit(dds_pins.dr_ctl, exp_ramp.second, "dr_ctl after settle");
				compare_dir(observed_dir(dr_first, dds_pins.dr_ctl), exp_ramp.dir, i);
			end
			level_before = exp_ramp.second;
		end

		// an empty store blocks the next sweep
		pulse_request('{1'b0, 1'b0, 1'b1});
		compare_count(stored_count, '0);
		edges_before = sclk_edges;
		updates_before = update_pulses;
		pulse_request('{1'b0, 1'b1, 1'b0});
		repeat (QUIET_CYCLES) @(negedge SCLK_PE_3);
		compare_int(sclk_edges, edges_before, "sclk edges after clear");
		compare_int(update_pulses, updates_before, "io_update pulses after clear");
		compare_int(int'(sweep_index), 0, "sweep_index after clear");

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
source/dds_regs_pkg.sv
source/dds_ctrl_pkg.sv
source/serial_frame_shifter.sv
source/sweep_store.sv
source/init_sequencer.sv
source/ramp_direction_ctl.sv
source/sweep_player.sv
source/dds_sweep_ctrl.sv
verif/tb_dds_sweep_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dds_sweep_ctrl -f list.f -o tb_dds_sweep_ctrl \
	> "$log" 2>&1 \
	&& ./obj_dir/tb_dds_sweep_ctrl >> "$log" 2>&1 \
	|| echo "build or simulation did not complete" >> "$log"

cat "$log"

# only a run that printed the pass line counts as passed
grep -q '^\*\*\* TEST PASSED \*\*\*$' "$log" && exit 0 || exit 1
